//--- dense_core.f
common/dense_pkg.sv
hw/operand_fetch.sv
hw/operand_buffer.sv
hw/dot_accumulate.sv
hw/dense_core.sv
test/dense_core_checker.sv
test/dense_core_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module dense_core_tb \
   -f dense_core.f -o dense_core_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/dense_core_sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1

//--- test/dense_core_stimulus.txt
// all values hex; a job is: num_of_input num_of_output data_words, then the data words,
// then data_words weight words per node, then one expected result per node; 0 ends the list
// job 0, full block with 0x80 and 0x7f bytes
00000020 00000001 00000008
807f807f 807f807f 807f807f 807f807f 80808080 80808080 80808080 80808080
80807f7f 80807f7f 80807f7f 80807f7f 80808080 80808080 80808080 80808080
00040004
// job 1, 100 inputs over three nodes, last block partial
00000064 00000003 00000019
80800101 01010101 01010101 01010101 01010101 01010101 01010101 01010101
01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101
01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101
01010101
02020202 02020202 02020202 02020202 02020202 02020202 02020202 02020202
02020202 02020202 02020202 02020202 02020202 02020202 02020202 02020202
02020202 02020202 02020202 02020202 02020202 02020202 02020202 02020202
02020202
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff
7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
7f7f7f7f
fffffec4 0000009e ffffb19e
// jobs 2 to 5, byte masking inside a word
00000001 00000001 00000001
03050709
ff020304
fffffffd
00000002 00000001 00000001
03050709
ff020304
00000007
00000003 00000001 00000001
03050709
ff020304
0000001c
00000005 00000001 00000002
03050709 0b0d0f11
ff020304 fe050505
0000002a
00000000

//--- test/dense_core_tb.sv
`timescale 1ns/1ns

module dense_core_tb;
   import dense_pkg::*;

   localparam int STIM_WORDS   = 512;
   localparam int DATA_DEPTH   = 1024;
   localparam int WEIGHT_DEPTH = 4096;
   localparam int OUT_DEPTH    = 256;
   localparam int WAIT_LIMIT   = 5000;
   localparam int HOLD_CYCLES  = 5;

   logic   nnclk = 1'b0;
   logic   nnreset_n;
   logic   nnstart;
   logic   nnend;
   count_t num_of_input;
   count_t num_of_output;
   addr_t  data_addr;
   word_t  data_dout = '0;
   addr_t  weight_addr;
   word_t  weight_dout = '0;
   addr_t  output_addr;
   acc_t   output_din;
   logic   output_we;

   word_t  stim [STIM_WORDS];
   word_t  data_mem [DATA_DEPTH];
   word_t  weight_mem [WEIGHT_DEPTH];
   word_t  out_mem [OUT_DEPTH];

   int     value_errors;
   int     order_errors = 0;
   int     timeouts;
   int     write_total = 0;
   int     job_base;
   string  test_name;

   dense_core dut (
      .nnclk, .nnreset_n, .nnstart, .nnend,
      .num_of_input, .num_of_output,
      .data_addr, .data_dout,
      .weight_addr, .weight_dout,
      .output_addr, .output_din, .output_we
   );

   always #50 nnclk = ~nnclk;

   // memories answer one cycle after the address
   always @(posedge nnclk) begin
      data_dout   <= data_mem[data_addr[11:2]];
      weight_dout <= weight_mem[weight_addr[13:2]];
      if (output_we) begin
         out_mem[output_addr[9:2]] <= output_din;
      end
   end

   // output writes must walk 0, 4, 8 in node order
   always @(negedge nnclk) begin
      if (nnreset_n && output_we) begin
         if (output_addr !== addr_t'((write_total - job_base) * WORD_BYTES)) begin
            order_errors++;
            $display("[FAIL] %s output_addr: expected %h, actual %h", test_name,
                     addr_t'((write_total - job_base) * WORD_BYTES), output_addr);
         end
         write_total++;
      end
   end

   // nonzero background, so unmasked stray bytes show up in the sums
   function automatic word_t data_fill(input int unsigned idx);
      return 32'h9e37_79b9 ^ (idx << 7) ^ idx;
   endfunction

   function automatic word_t weight_fill(input int unsigned idx);
      return 32'h6c07_8965 ^ (idx << 5) ^ idx;
   endfunction

   task automatic wait_nnend(input logic level);
      int cycles;
      cycles = 0;
      while (nnend !== level && cycles < WAIT_LIMIT) begin
         @(negedge nnclk);
         cycles++;
      end
      if (nnend !== level) begin
         timeouts++;
         $display("nnend did not go to %b within %0d cycles in %s", level, WAIT_LIMIT,
                  test_name);
      end
   endtask

   initial begin
      int pos;
      int job;
      int n_in;
      int n_out;
      int n_words;
      int base;
      nnreset_n     = 1'b0;
      nnstart       = 1'b0;
      num_of_input  = '0;
      num_of_output = '0;
      value_errors  = 0;
      timeouts      = 0;
      job_base      = 0;
      test_name     = "reset";
      for (int i = 0; i < STIM_WORDS; i++) begin
         stim[i] = '0;
      end
      $readmemh("test/dense_core_stimulus.txt", stim);
      repeat (8) @(negedge nnclk);
      nnreset_n = 1'b1;
      if (nnend !== 1'b0 || output_we !== 1'b0) begin
         value_errors++;
         $display("[FAIL] reset: expected nnend 0 output_we 0, actual %b %b", nnend, output_we);
      end

      pos = 0;
      job = 0;
      while (pos < STIM_WORDS - 3 && stim[pos] != 0) begin
         n_in    = int'(stim[pos]);
         n_out   = int'(stim[pos + 1]);
         n_words = int'(stim[pos + 2]);
         pos += 3;
         for (int i = 0; i < DATA_DEPTH; i++) begin
            data_mem[i] = data_fill(i);
         end
         for (int i = 0; i < WEIGHT_DEPTH; i++) begin
            weight_mem[i] = weight_fill(i);
         end
         for (int w = 0; w < n_words; w++) begin
            data_mem[w] = stim[pos];
            pos++;
         end
         // each node has its own weight row
         for (int k = 0; k < n_out; k++) begin
            for (int w = 0; w < n_words; w++) begin
               weight_mem[k * (WEIGHT_STRIDE / WORD_BYTES) + w] = stim[pos];
               pos++;
            end
         end

         test_name = $sformatf("job %0d (%0d inputs, %0d nodes)", job, n_in, n_out);
         $display("running %s", test_name);
         @(negedge nnclk);
         base          = write_total;
         job_base      = base;
         num_of_input  = count_t'(n_in);
         num_of_output = count_t'(n_out);
         nnstart       = 1'b1;
         wait_nnend(1'b1);
         if (timeouts != 0) begin
            break;
         end

         // all writes are done by the time nnend rises
         if (write_total - base != n_out) begin
            value_errors++;
            $display("[FAIL] %s write count: expected %0d, actual %0d", test_name, n_out,
                     write_total - base);
         end
         for (int k = 0; k < n_out; k++) begin
            if (out_mem[k] !== stim[pos + k]) begin
               value_errors++;
               $display("[FAIL] %s node %0d: expected %h, actual %h", test_name, k,
                        stim[pos + k], out_mem[k]);
            end
         end
         pos += n_out;

         for (int c = 0; c < HOLD_CYCLES; c++) begin
            @(negedge nnclk);
            if (nnend !== 1'b1) begin
               value_errors++;
               $display("[FAIL] %s nnend hold: expected 1, actual %b", test_name, nnend);
            end
         end
         nnstart = 1'b0;
         wait_nnend(1'b0);
         if (timeouts != 0) begin
            break;
         end
         job++;
      end

      if (job == 0 && timeouts == 0) begin
         value_errors++;
         $display("no job records were read from the stimulus file");
      end
      $display("errors: %0d value, %0d order, %0d timeout", value_errors, order_errors,
               timeouts);
      if (value_errors == 0 && order_errors == 0 && timeouts == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- test/dense_core_checker.sv
`timescale 1ns/1ns

module dense_core_checker (
   input logic nnclk,
   input logic nnreset_n,
   input logic nnstart,
   input logic nnend,
   input logic output_we
);

   // one write per node, nodes are never shorter than a block
   we_single: assert property (@(posedge nnclk) disable iff (!nnreset_n)
      output_we |=> !output_we)
      else $error("output_we high on two cycles in a row");

   end_after_writes: assert property (@(posedge nnclk) disable iff (!nnreset_n)
      output_we |-> !nnend)
      else $error("nnend high during an output write");

   // level protocol, nnend only drops once nnstart was seen low
   end_falls_late: assert property (@(posedge nnclk) disable iff (!nnreset_n)
      $fell(nnend) |-> !$past(nnstart))
      else $error("nnend fell while nnstart was still high");

endmodule

bind dense_core dense_core_checker u_checker (
   .nnclk(nnclk),
   .nnreset_n(nnreset_n),
   .nnstart(nnstart),
   .nnend(nnend),
   .output_we(output_we)
);

//--- hw/dense_core.sv
`timescale 1ns/1ns

module dense_core (
   input  logic             nnclk,
   input  logic             nnreset_n,
   input  logic             nnstart,
   output logic             nnend,
   input  dense_pkg::count_t num_of_input,
   input  dense_pkg::count_t num_of_output,
   output dense_pkg::addr_t data_addr,
   input  dense_pkg::word_t data_dout,
   output dense_pkg::addr_t weight_addr,
   input  dense_pkg::word_t weight_dout,
   output dense_pkg::addr_t output_addr,
   output dense_pkg::acc_t  output_din,
   output logic             output_we
);
   import dense_pkg::*;

   logic      job_start;
   logic      word_valid;
   lane_idx_t word_index;
   byte_cnt_t byte_count;
   logic      block_end;
   logic      node_end;
   logic      block_valid;
   logic      node_last;
   operand_t  data_lanes [BLOCK_LEN];
   operand_t  weight_lanes [BLOCK_LEN];

   operand_fetch u_fetch (
      .nnclk, .nnreset_n, .nnstart, .nnend,
      .num_of_input, .num_of_output,
      .data_addr, .weight_addr,
      .job_start,
      .word_valid, .word_index, .byte_count,
      .block_end, .node_end
   );

   operand_buffer u_buffer (
      .nnclk, .nnreset_n,
      .word_valid, .word_index, .byte_count,
      .block_end, .node_end,
      .data_dout, .weight_dout,
      .data_lanes, .weight_lanes,
      .block_valid, .node_last
   );

   dot_accumulate u_dot (
      .nnclk, .nnreset_n, .job_start,
      .data_lanes, .weight_lanes,
      .block_valid, .node_last,
      .output_addr, .output_din, .output_we
   );

endmodule

//--- hw/dot_accumulate.sv
`timescale 1ns/1ns

module dot_accumulate (
   input  logic                nnclk,
   input  logic                nnreset_n,
   input  logic                job_start,
   input  dense_pkg::operand_t data_lanes [dense_pkg::BLOCK_LEN],
   input  dense_pkg::operand_t weight_lanes [dense_pkg::BLOCK_LEN],
   input  logic                block_valid,
   input  logic                node_last,
   output dense_pkg::addr_t    output_addr,
   output dense_pkg::acc_t     output_din,
   output logic                output_we
);
   import dense_pkg::*;

   product_t prod [BLOCK_LEN];
   acc_t     tree_sum;
   acc_t     acc;

   for (genvar i = 0; i < BLOCK_LEN; i++) begin : g_mul
      assign prod[i] = data_lanes[i] * weight_lanes[i];
   end

   // balanced tree, one extra bit per level keeps every partial sum exact
   for (genvar l = 0; l < $clog2(BLOCK_LEN); l++) begin : g_lvl
      logic signed [$bits(product_t) + l:0] s [BLOCK_LEN >> (l + 1)];
      for (genvar n = 0; n < (BLOCK_LEN >> (l + 1)); n++) begin : g_node
         if (l == 0) begin : g_leaf
            assign s[n] = prod[2 * n] + prod[2 * n + 1];
         end else begin : g_inner
            assign s[n] = g_lvl[l - 1].s[2 * n] + g_lvl[l - 1].s[2 * n + 1];
         end
      end
   end

   assign tree_sum = acc_t'(g_lvl[$clog2(BLOCK_LEN) - 1].s[0]);

   always_ff @(posedge nnclk or negedge nnreset_n) begin
      if (!nnreset_n) begin
         acc         <= '0;
         output_addr <= '0;
         output_we   <= 1'b0;
      end else begin
         output_we <= block_valid && node_last;
         if (job_start) begin
            acc         <= '0;
            output_addr <= '0;
         end else begin
            if (block_valid) begin
               acc <= node_last ? '0 : acc + tree_sum;
            end
            // address moves on after the write cycle
            if (output_we) begin
               output_addr <= output_addr + WORD_BYTES;
            end
         end
      end
   end

   always_ff @(posedge nnclk) begin
      if (block_valid && node_last) begin
         output_din <= acc + tree_sum;
      end
   end

endmodule

//--- hw/operand_buffer.sv
`timescale 1ns/1ns

module operand_buffer (
   input  logic                 nnclk,
   input  logic                 nnreset_n,
   input  logic                 word_valid,
   input  dense_pkg::lane_idx_t word_index,
   input  dense_pkg::byte_cnt_t byte_count,
   input  logic                 block_end,
   input  logic                 node_end,
   input  dense_pkg::word_t     data_dout,
   input  dense_pkg::word_t     weight_dout,
   output dense_pkg::operand_t  data_lanes [dense_pkg::BLOCK_LEN],
   output dense_pkg::operand_t  weight_lanes [dense_pkg::BLOCK_LEN],
   output logic                 block_valid,
   output logic                 node_last
);
   import dense_pkg::*;

   // msb first, bytes past the input end are forced to zero
   always_ff @(posedge nnclk) begin
      if (word_valid) begin
         for (int b = 0; b < WORD_BYTES; b++) begin
            if (b < byte_count) begin
               data_lanes[word_index * WORD_BYTES + b]   <= data_dout[8 * (3 - b) +: 8];
               weight_lanes[word_index * WORD_BYTES + b] <= weight_dout[8 * (3 - b) +: 8];
            end else begin
               data_lanes[word_index * WORD_BYTES + b]   <= '0;
               weight_lanes[word_index * WORD_BYTES + b] <= '0;
            end
         end
      end
   end

   // lanes hold for this one cycle, the next word lands at its end
   always_ff @(posedge nnclk or negedge nnreset_n) begin
      if (!nnreset_n) begin
         block_valid <= 1'b0;
         node_last   <= 1'b0;
      end else begin
         block_valid <= word_valid && block_end;
         node_last   <= word_valid && block_end && node_end;
      end
   end

endmodule

//--- hw/operand_fetch.sv
`timescale 1ns/1ns

module operand_fetch (
   input  logic                  nnclk,
   input  logic                  nnreset_n,
   input  logic                  nnstart,
   output logic                  nnend,
   input  dense_pkg::count_t     num_of_input,
   input  dense_pkg::count_t     num_of_output,
   output dense_pkg::addr_t      data_addr,
   output dense_pkg::addr_t      weight_addr,
   output logic                  job_start,
   output logic                  word_valid,
   output dense_pkg::lane_idx_t  word_index,
   output dense_pkg::byte_cnt_t  byte_count,
   output logic                  block_end,
   output logic                  node_end
);
   import dense_pkg::*;

   fetch_state_t state;
   count_t       in_len;
   count_t       out_cnt;
   count_t       node_idx;
   count_t       blk_base;
   addr_t        row_base;
   lane_idx_t    word_idx;
   logic [1:0]   drain_cnt;

   count_t       word_off;
   count_t       remain;
   byte_cnt_t    cur_bytes;
   logic         last_word;
   logic         last_block;
   logic         last_node;

   // bytes of the current word that fall inside the input length
   always_comb begin
      word_off = blk_base + count_t'(word_idx) * WORD_BYTES;
      remain   = in_len - word_off;
      if (word_off >= in_len) begin
         cur_bytes = '0;
      end else if (remain >= count_t'(WORD_BYTES)) begin
         cur_bytes = byte_cnt_t'(WORD_BYTES);
      end else begin
         cur_bytes = remain[2:0];
      end
   end

   assign last_word  = (word_idx == lane_idx_t'(BLOCK_WORDS - 1));
   assign last_block = ((blk_base + BLOCK_LEN) >= in_len);
   assign last_node  = (node_idx == out_cnt - 1);

   always_ff @(posedge nnclk or negedge nnreset_n) begin
      if (!nnreset_n) begin
         state       <= FETCH_IDLE;
         in_len      <= '0;
         out_cnt     <= '0;
         node_idx    <= '0;
         blk_base    <= '0;
         row_base    <= '0;
         word_idx    <= '0;
         drain_cnt   <= '0;
         data_addr   <= '0;
         weight_addr <= '0;
         nnend       <= 1'b0;
      end else begin
         case (state)
            FETCH_IDLE: begin
               if (nnstart) begin
                  in_len      <= (num_of_input > count_t'(MAX_INPUT)) ?
                                 count_t'(MAX_INPUT) : num_of_input;
                  out_cnt     <= num_of_output;
                  node_idx    <= '0;
                  blk_base    <= '0;
                  row_base    <= '0;
                  word_idx    <= '0;
                  data_addr   <= '0;
                  weight_addr <= '0;
                  state       <= FETCH_STREAM;
               end
            end
            FETCH_STREAM: begin
               word_idx <= word_idx + 1'b1;
               if (!last_word || !last_block) begin
                  data_addr   <= data_addr + WORD_BYTES;
                  weight_addr <= weight_addr + WORD_BYTES;
                  if (last_word) begin
                     blk_base <= blk_base + BLOCK_LEN;
                  end
               end else begin
                  // node boundary, rewind data and jump to the next weight row
                  blk_base  <= '0;
                  data_addr <= '0;
                  if (last_node) begin
                     drain_cnt <= '0;
                     state     <= FETCH_DRAIN;
                  end else begin
                     node_idx    <= node_idx + 1;
                     row_base    <= row_base + WEIGHT_STRIDE;
                     weight_addr <= row_base + WEIGHT_STRIDE;
                  end
               end
            end
            FETCH_DRAIN: begin
               drain_cnt <= drain_cnt + 1'b1;
               if (drain_cnt == 2'(DRAIN_CYCLES - 1)) begin
                  nnend <= 1'b1;
                  state <= FETCH_DONE;
               end
            end
            FETCH_DONE: begin
               if (!nnstart) begin
                  nnend <= 1'b0;
                  state <= FETCH_IDLE;
               end
            end
            default: state <= FETCH_IDLE;
         endcase
      end
   end

   // tags follow the address by one cycle, in step with the memory read
   always_ff @(posedge nnclk or negedge nnreset_n) begin
      if (!nnreset_n) begin
         job_start  <= 1'b0;
         word_valid <= 1'b0;
         block_end  <= 1'b0;
         node_end   <= 1'b0;
      end else begin
         job_start  <= (state == FETCH_IDLE) && nnstart;
         word_valid <= (state == FETCH_STREAM);
         block_end  <= (state == FETCH_STREAM) && last_word;
         node_end   <= (state == FETCH_STREAM) && last_word && last_block;
      end
   end

   always_ff @(posedge nnclk) begin
      word_index <= word_idx;
      byte_count <= cur_bytes;
   end

endmodule

//--- common/dense_pkg.sv
package dense_pkg;

   // block geometry
   localparam int BLOCK_LEN     = 32;
   localparam int WORD_BYTES    = 4;
   localparam int BLOCK_WORDS   = 8;

   // job limits and memory layout
   localparam int WEIGHT_STRIDE = 1024;
   localparam int MAX_INPUT     = 1024;

   // last address to last output write, through buffer and accumulator
   localparam int DRAIN_CYCLES  = 3;

   typedef logic [31:0]        addr_t;
   typedef logic [31:0]        word_t;
   typedef logic [31:0]        count_t;
   typedef logic signed [7:0]  operand_t;
   typedef logic signed [15:0] product_t;
   typedef logic signed [31:0] acc_t;
   typedef logic [2:0]         lane_idx_t;
   typedef logic [2:0]         byte_cnt_t;

   typedef enum logic [1:0] {
      FETCH_IDLE,
      FETCH_STREAM,
      FETCH_DRAIN,
      FETCH_DONE
   } fetch_state_t;

endpackage
